//--- compile.f
+incdir+include
rtl/sched_pkg.sv
rtl/tdma_policy.sv
rtl/edf_policy.sv
rtl/fp_policy.sv
rtl/queue_arbiter.sv
rtl/issue_sequencer.sv
rtl/mem_scheduler.sv
dv/sched_tb.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f compile.f --top-module sched_tb \
    -Mdir obj_dir -o sched_sim || exit 1
sim_out="$(./obj_dir/sched_sim)" || true
echo "$sim_out"
echo "$sim_out" | grep -qx "Test OK" && exit 0 || exit 1

//--- dv/sched_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "sched_config.svh"

module sched_tb;

    import sched_pkg::*;

    localparam int n_queues      = `SCHED_QUEUES;
    localparam int grant_timeout = 200;

    logic           clock;
    logic           reset;
    sched_mode_e    mode;
    queue_cfg_vec_t cfg;
    queue_status_t  status;
    logic           consumed;
    queue_id_t      id;
    logic           enable;
    queue_mask_t    consumed_ack;

    logic [31:0] lfsr;
    int          error_count;
    int          check_count;
    int          grant_count;
    string       test_name;
    logic        armed;
    // reset seen at the previous falling edge, dut has taken a reset edge since
    logic        reset_d1;

    // model state, counted from the first cycle out of reset
    queue_id_t                   tdma_owner;
    logic [`SCHED_TIME_BITS-1:0] tdma_count;
    logic [`SCHED_TIME_BITS-1:0] edf_elapsed [n_queues];
    // picks one and two cycles back
    queue_id_t                   pick_d1;
    queue_id_t                   pick_d2;
    queue_id_t                   exp_id;
    logic                        exp_granted;
    logic                        cons_d1;
    logic                        cons_d2;

    mem_scheduler u_dut
    (
        .clock        (clock),
        .reset        (reset),
        .mode         (mode),
        .cfg          (cfg),
        .status       (status),
        .consumed     (consumed),
        .id           (id),
        .enable       (enable),
        .consumed_ack (consumed_ack)
    );

    initial
    begin
        clock = 1'b0;
        forever
        begin
            #2 clock = ~clock;
        end
    end

    ////////////////////////////////////////////////////////////
    // random source and reference model
    ////////////////////////////////////////////////////////////

    // galois lfsr, one step per bit
    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int b = 0; b < n; b++)
        begin
            value = {value[30:0], lfsr[0]};
            lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return value;
    endfunction

    // choice rule on the inputs of one cycle
    function automatic queue_id_t expected_pick(input sched_mode_e m, input queue_cfg_vec_t c,
                                                input queue_status_t s);
        queue_id_t                   pick;
        logic [`SCHED_TIME_BITS-1:0] slack;
        logic [`SCHED_TIME_BITS-1:0] best_slack;
        logic [`SCHED_PRIO_BITS-1:0] best_prio;
        logic                        found;
        pick       = '0;
        best_slack = '1;
        best_prio  = '0;
        found      = 1'b0;
        if (s.full != '0)
        begin
            // highest full index overrides any policy
            for (int q = 0; q < n_queues; q++)
            begin
                if (s.full[q])
                begin
                    pick = queue_id_t'(q);
                end
            end
        end
        else if (m == mode_edf)
        begin
            for (int q = 0; q < n_queues; q++)
            begin
                slack = (edf_elapsed[q] < c[q].deadline) ? c[q].deadline - edf_elapsed[q] : '0;
                if (!found || slack < best_slack)
                begin
                    pick       = queue_id_t'(q);
                    best_slack = slack;
                    found      = 1'b1;
                end
            end
        end
        else if (m == mode_fp)
        begin
            // all empty leaves queue 0
            for (int q = 0; q < n_queues; q++)
            begin
                if (!s.empty[q] && (!found || c[q].prio > best_prio))
                begin
                    pick      = queue_id_t'(q);
                    best_prio = c[q].prio;
                    found     = 1'b1;
                end
            end
        end
        else
        begin
            // tdma and the spare code
            pick = tdma_owner;
        end
        return pick;
    endfunction

    // step slot counter and release timers by one clock
    function automatic void advance_model();
        logic [`SCHED_TIME_BITS-1:0] span;
        span = (cfg[tdma_owner].period == '0) ? `SCHED_TIME_BITS'(1) : cfg[tdma_owner].period;
        if (tdma_count == span - 1'b1)
        begin
            tdma_count = '0;
            tdma_owner = (tdma_owner == queue_id_t'(n_queues - 1)) ? '0 : tdma_owner + 1'b1;
        end
        else
        begin
            tdma_count = tdma_count + 1'b1;
        end
        for (int q = 0; q < n_queues; q++)
        begin
            span = (cfg[q].period == '0) ? `SCHED_TIME_BITS'(1) : cfg[q].period;
            edf_elapsed[q] = (edf_elapsed[q] == span - 1'b1) ? '0 : edf_elapsed[q] + 1'b1;
        end
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (expected != actual)
        begin
            error_count++;
            $display("mismatch %s %s: expected %0h, actual %0h", test_name, what,
                     expected, actual);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // compare process, outputs are stable at the falling edge
    ////////////////////////////////////////////////////////////

    always @(negedge clock)
    begin
        queue_mask_t exp_ack;
        if (reset)
        begin
            // first reset cycle still shows the old outputs
            if (reset_d1)
            begin
                check_value("enable", 32'(1'b0), 32'(enable));
                check_value("id", 32'(0), 32'(id));
                check_value("consumed_ack", 32'(0), 32'(consumed_ack));
            end
            tdma_owner  = '0;
            tdma_count  = '0;
            pick_d1     = '0;
            pick_d2     = '0;
            exp_id      = '0;
            exp_granted = 1'b0;
            cons_d1     = 1'b0;
            cons_d2     = 1'b0;
            for (int q = 0; q < n_queues; q++)
            begin
                edf_elapsed[q] = '0;
            end
        end
        else if (armed)
        begin
            // ack follows a rising consumed by one cycle
            exp_ack = (cons_d1 && !cons_d2 && exp_granted) ? queue_mask_t'(1) << exp_id : '0;
            check_value("consumed_ack", 32'(exp_ack), 32'(consumed_ack));
            if (enable)
            begin
                exp_id      = pick_d2;
                exp_granted = 1'b1;
            end
            check_value("id", 32'(exp_id), 32'(id));
            cons_d2 = cons_d1;
            cons_d1 = consumed;
            pick_d2 = pick_d1;
            pick_d1 = expected_pick(mode, cfg, status);
            advance_model();
        end
        reset_d1 = reset;
        armed    = 1'b1;
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    task automatic start_phase(input string name, input sched_mode_e m,
                               input queue_cfg_vec_t c, input queue_status_t s);
        @(posedge clock);
        test_name = name;
        mode   <= m;
        cfg    <= c;
        status <= s;
        reset  <= 1'b1;
        repeat (3) @(posedge clock);
        reset <= 1'b0;
    endtask

    task automatic pulse_consumed();
        @(posedge clock);
        consumed <= 1'b1;
        @(posedge clock);
        consumed <= 1'b0;
    endtask

    task automatic wait_grant();
        int cycles;
        cycles = 0;
        @(negedge clock);
        while (!enable && cycles < grant_timeout)
        begin
            @(negedge clock);
            cycles++;
        end
        if (enable)
        begin
            grant_count++;
        end
        else
        begin
            error_count++;
            $display("%s: no grant within %0d cycles", test_name, grant_timeout);
        end
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles)
        begin
            @(negedge clock);
            check_count++;
            if (enable)
            begin
                error_count++;
                $display("%s: enable pulsed although no grant was possible", test_name);
            end
        end
    endtask

    initial
    begin
        queue_cfg_vec_t next_cfg;
        queue_status_t  next_status;
        lfsr        = 32'h9902_d36a;
        error_count = 0;
        check_count = 0;
        grant_count = 0;
        armed       = 1'b0;
        reset_d1    = 1'b0;
        test_name   = "reset";
        reset       = 1'b1;
        mode        = mode_tdma;
        cfg         = '0;
        consumed    = 1'b0;
        next_cfg    = '0;
        next_status.full  = '0;
        next_status.empty = '1;
        status      = next_status;

        // all empty, strobes before any grant give no ack
        start_phase("reset", mode_tdma, next_cfg, next_status);
        expect_quiet(10);
        pulse_consumed();
        expect_quiet(6);

        // fixed priority with steady random masks
        start_phase("fp", mode_fp, next_cfg, next_status);
        for (int r = 0; r < 6; r++)
        begin
            for (int q = 0; q < n_queues; q++)
            begin
                next_cfg[q].prio = `SCHED_PRIO_BITS'(draw_bits(`SCHED_PRIO_BITS));
            end
            next_status.empty = queue_mask_t'(draw_bits(n_queues));
            if (next_status.empty == '1)
            begin
                next_status.empty[r % n_queues] = 1'b0;
            end
            @(posedge clock);
            cfg    <= next_cfg;
            status <= next_status;
            repeat (2)
            begin
                pulse_consumed();
                wait_grant();
            end
        end

        // tdma with short random slots
        next_status.empty = '0;
        for (int q = 0; q < n_queues; q++)
        begin
            next_cfg[q].period = `SCHED_TIME_BITS'(draw_bits(3));
        end
        start_phase("tdma", mode_tdma, next_cfg, next_status);
        repeat (10)
        begin
            pulse_consumed();
            wait_grant();
        end

        // edf with random windows
        for (int q = 0; q < n_queues; q++)
        begin
            next_cfg[q].period   = `SCHED_TIME_BITS'(draw_bits(4));
            next_cfg[q].deadline = `SCHED_TIME_BITS'(draw_bits(4));
        end
        start_phase("edf", mode_edf, next_cfg, next_status);
        repeat (10)
        begin
            pulse_consumed();
            wait_grant();
        end

        // full override in every mode code
        start_phase("full", mode_tdma, next_cfg, next_status);
        for (int r = 0; r < 8; r++)
        begin
            next_status.full = queue_mask_t'(draw_bits(n_queues));
            // at least one queue full each round
            if (next_status.full == '0)
            begin
                next_status.full[r % n_queues] = 1'b1;
            end
            @(posedge clock);
            mode   <= sched_mode_e'(2'(r));
            status <= next_status;
            pulse_consumed();
            wait_grant();
        end

        // full queue that is also empty blocks the grant
        next_status.full  = queue_mask_t'(1) << draw_bits(2);
        next_status.empty = next_status.full;
        @(posedge clock);
        status <= next_status;
        repeat (3) @(posedge clock);
        pulse_consumed();
        expect_quiet(10);
        // ack still routed to the last grant
        pulse_consumed();
        expect_quiet(4);

        $display("%0d grants, %0d checks, %0d errors", grant_count, check_count, error_count);
        if (error_count == 0)
        begin
            $display("Test OK");
        end
        else
        begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/mem_scheduler.sv
`timescale 1ns/1ps
`default_nettype none

module mem_scheduler
(
    input  logic                      clock,
    input  logic                      reset,
    input  sched_pkg::sched_mode_e    mode,
    input  sched_pkg::queue_cfg_vec_t cfg,
    input  sched_pkg::queue_status_t  status,
    input  logic                      consumed,
    output sched_pkg::queue_id_t      id,
    output logic                      enable,
    output sched_pkg::queue_mask_t    consumed_ack
);

    import sched_pkg::*;

    // policy picks and registered candidate
    queue_id_t tdma_sel;
    queue_id_t edf_sel;
    queue_id_t fp_sel;
    queue_id_t candidate;

    tdma_policy u_tdma
    (
        .clock     (clock),
        .reset     (reset),
        .cfg       (cfg),
        .selection (tdma_sel)
    );

    edf_policy u_edf
    (
        .clock     (clock),
        .reset     (reset),
        .cfg       (cfg),
        .selection (edf_sel)
    );

    fp_policy u_fp
    (
        .cfg       (cfg),
        .empty     (status.empty),
        .selection (fp_sel)
    );

    queue_arbiter u_arbiter
    (
        .clock     (clock),
        .reset     (reset),
        .mode      (mode),
        .full      (status.full),
        .tdma_sel  (tdma_sel),
        .edf_sel   (edf_sel),
        .fp_sel    (fp_sel),
        .candidate (candidate)
    );

    issue_sequencer u_sequencer
    (
        .clock        (clock),
        .reset        (reset),
        .candidate    (candidate),
        .empty        (status.empty),
        .consumed     (consumed),
        .id           (id),
        .enable       (enable),
        .consumed_ack (consumed_ack)
    );

endmodule

`default_nettype wire

//--- rtl/issue_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module issue_sequencer
(
    input  logic                   clock,
    input  logic                   reset,
    input  sched_pkg::queue_id_t   candidate,
    input  sched_pkg::queue_mask_t empty,
    input  logic                   consumed,
    output sched_pkg::queue_id_t   id,
    output logic                   enable,
    output sched_pkg::queue_mask_t consumed_ack
);

    import sched_pkg::*;

    issue_state_e state;
    issue_state_e state_next;
    // set once the first grant goes out
    logic         granted;
    logic         consumed_q;
    logic         cand_ready;
    logic         consumed_rise;

    assign cand_ready    = ~empty[candidate];
    assign consumed_rise = consumed & ~consumed_q;

    ////////////////////////////////////////////////////////////
    // grant fsm
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        state_next = st_idle;
        case (state)
            st_idle:
            begin
                // first grant needs no consumed
                if (cand_ready && (!granted || consumed))
                begin
                    state_next = st_check;
                end
            end
            // candidate must stay non-empty over both check cycles
            st_check:  state_next = cand_ready ? st_settle : st_idle;
            st_settle: state_next = cand_ready ? st_issue : st_idle;
            default:   state_next = st_idle;
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state        <= st_idle;
            granted      <= 1'b0;
            id           <= '0;
            consumed_q   <= 1'b0;
            consumed_ack <= '0;
        end
        else
        begin
            state      <= state_next;
            consumed_q <= consumed;
            // latch id on the edge into st_issue
            if ((state == st_settle) && (state_next == st_issue))
            begin
                id      <= candidate;
                granted <= 1'b1;
            end
            // ack to the queue granted when consumed rose
            consumed_ack <= (consumed_rise && granted) ? (queue_mask_t'(1) << id) : '0;
        end
    end

    // one-cycle grant pulse
    assign enable = (state == st_issue);

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    a_enable_pulse: assert property (@(posedge clock) disable iff (reset)
        enable |=> !enable)
        else $error("enable held for two cycles");

    a_id_on_grant: assert property (@(posedge clock) disable iff (reset)
        (id != $past(id)) |-> enable)
        else $error("id changed outside a grant");

    a_ack_onehot: assert property (@(posedge clock) disable iff (reset)
        $onehot0(consumed_ack))
        else $error("consumed_ack has more than one bit set");

endmodule

`default_nettype wire

//--- rtl/queue_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "sched_config.svh"

module queue_arbiter
(
    input  logic                   clock,
    input  logic                   reset,
    input  sched_pkg::sched_mode_e mode,
    input  sched_pkg::queue_mask_t full,
    input  sched_pkg::queue_id_t   tdma_sel,
    input  sched_pkg::queue_id_t   edf_sel,
    input  sched_pkg::queue_id_t   fp_sel,
    output sched_pkg::queue_id_t   candidate
);

    import sched_pkg::*;

    queue_id_t mode_sel;
    queue_id_t full_sel;
    logic      any_full;

    // policy mux
    always_comb
    begin
        case (mode)
            mode_edf: mode_sel = edf_sel;
            mode_fp:  mode_sel = fp_sel;
            default:  mode_sel = tdma_sel;
        endcase
    end

    // full queue override, highest index wins
    always_comb
    begin
        full_sel = '0;
        for (int q = 0; q < `SCHED_QUEUES; q++)
        begin
            if (full[q])
            begin
                full_sel = queue_id_t'(q);
            end
        end
    end

    assign any_full = |full;

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            candidate <= '0;
        end
        else
        begin
            candidate <= any_full ? full_sel : mode_sel;
        end
    end

    // a full queue always takes the next candidate slot
    a_full_wins: assert property (@(posedge clock) disable iff (reset)
        any_full |=> |($past(full) & (queue_mask_t'(1) << candidate)))
        else $error("candidate is not a full queue");

endmodule

`default_nettype wire

//--- rtl/fp_policy.sv
`timescale 1ns/1ps
`default_nettype none

`include "sched_config.svh"

module fp_policy
(
    input  sched_pkg::queue_cfg_vec_t cfg,
    input  sched_pkg::queue_mask_t    empty,
    output sched_pkg::queue_id_t      selection
);

    import sched_pkg::*;

    // scan all queues, keep the best one holding requests
    always_comb
    begin
        queue_id_t                   best_id;
        logic [`SCHED_PRIO_BITS-1:0] best_prio;
        logic                        found;
        best_id   = '0;
        best_prio = '0;
        found     = 1'b0;
        for (int q = 0; q < `SCHED_QUEUES; q++)
        begin
            // empty queues never win
            // strict compare keeps ties on the lowest index
            if (!empty[q] && (!found || (cfg[q].prio > best_prio)))
            begin
                best_id   = queue_id_t'(q);
                best_prio = cfg[q].prio;
                found     = 1'b1;
            end
        end
        // nothing pending falls back to queue 0
        selection = best_id;
    end

endmodule

`default_nettype wire

//--- rtl/edf_policy.sv
`timescale 1ns/1ps
`default_nettype none

`include "sched_config.svh"

module edf_policy
(
    input  logic                      clock,
    input  logic                      reset,
    input  sched_pkg::queue_cfg_vec_t cfg,
    output sched_pkg::queue_id_t      selection
);

    import sched_pkg::*;

    // cycles since each queue's last release
    logic [`SCHED_TIME_BITS-1:0] elapsed [`SCHED_QUEUES];
    logic [`SCHED_TIME_BITS-1:0] wrap_at [`SCHED_QUEUES];
    logic [`SCHED_TIME_BITS-1:0] slack   [`SCHED_QUEUES];

    always_comb
    begin
        for (int q = 0; q < `SCHED_QUEUES; q++)
        begin
            // zero period acts as one, timer stays at 0
            wrap_at[q] = (cfg[q].period == '0) ? '0 : cfg[q].period - 1'b1;
            // past the deadline means no slack left
            slack[q] = (elapsed[q] < cfg[q].deadline) ? cfg[q].deadline - elapsed[q] : '0;
        end
    end

    ////////////////////////////////////////////////////////////
    // release timers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock)
    begin
        for (int q = 0; q < `SCHED_QUEUES; q++)
        begin
            if (reset || (elapsed[q] >= wrap_at[q]))
            begin
                elapsed[q] <= '0;
            end
            else
            begin
                elapsed[q] <= elapsed[q] + 1'b1;
            end
        end
    end

    // least slack wins
    // strict compare keeps ties on the lowest index
    always_comb
    begin
        queue_id_t                   best_id;
        logic [`SCHED_TIME_BITS-1:0] best_slack;
        best_id    = '0;
        best_slack = slack[0];
        for (int q = 1; q < `SCHED_QUEUES; q++)
        begin
            if (slack[q] < best_slack)
            begin
                best_id    = queue_id_t'(q);
                best_slack = slack[q];
            end
        end
        selection = best_id;
    end

endmodule

`default_nettype wire

//--- rtl/tdma_policy.sv
`timescale 1ns/1ps
`default_nettype none

`include "sched_config.svh"

module tdma_policy
(
    input  logic                      clock,
    input  logic                      reset,
    input  sched_pkg::queue_cfg_vec_t cfg,
    output sched_pkg::queue_id_t      selection
);

    import sched_pkg::*;

    localparam queue_id_t last_queue = queue_id_t'(`SCHED_QUEUES - 1);

    // current slot holder and cycles spent in its slot
    queue_id_t                   owner;
    logic [`SCHED_TIME_BITS-1:0] slot_count;
    logic [`SCHED_TIME_BITS-1:0] slot_len;
    logic                        slot_end;

    // slot length is the owner's period
    assign slot_len = cfg[owner].period;

    // zero-length slot hands over every cycle
    // >= also recovers if software shrinks a running slot
    assign slot_end = (slot_len == '0) || (slot_count >= slot_len - 1'b1);

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            owner      <= '0;
            slot_count <= '0;
        end
        else if (slot_end)
        begin
            // next queue in turn, wrap after the last one
            slot_count <= '0;
            owner      <= (owner == last_queue) ? '0 : owner + 1'b1;
        end
        else
        begin
            slot_count <= slot_count + 1'b1;
        end
    end

    assign selection = owner;

endmodule

`default_nettype wire

//--- rtl/sched_pkg.sv
`default_nettype none

`include "sched_config.svh"

package sched_pkg;

    // queue index and one flag per queue
    typedef logic [$clog2(`SCHED_QUEUES)-1:0] queue_id_t;
    typedef logic [`SCHED_QUEUES-1:0] queue_mask_t;

    // static per-queue settings written by software
    typedef struct packed {
        logic [`SCHED_TIME_BITS-1:0] period;
        logic [`SCHED_TIME_BITS-1:0] deadline;
        logic [`SCHED_PRIO_BITS-1:0] prio;
    } queue_cfg_t;

    // entry q belongs to queue q
    typedef queue_cfg_t [`SCHED_QUEUES-1:0] queue_cfg_vec_t;

    // levels reported by the queues
    typedef struct packed {
        queue_mask_t full;
        queue_mask_t empty;
    } queue_status_t;

    // policy select, code 3 falls back to tdma
    typedef enum logic [1:0] {
        mode_tdma = 2'd0,
        mode_edf  = 2'd1,
        mode_fp   = 2'd2
    } sched_mode_e;

    // grant sequencer states
    typedef enum logic [1:0] {
        st_idle   = 2'd0,
        st_check  = 2'd1,
        st_settle = 2'd2,
        st_issue  = 2'd3
    } issue_state_e;

endpackage

`default_nettype wire

//--- include/sched_config.svh
`ifndef SCHED_CONFIG_SVH
`define SCHED_CONFIG_SVH

// scheduler sizing, shared by the package and the RTL

// number of request queues behind the scheduler
`define SCHED_QUEUES 4

// period and deadline fields, counted in clock cycles
`define SCHED_TIME_BITS 16

// fixed-priority level per queue
// larger value wins
`define SCHED_PRIO_BITS 4

`endif
